//--- Bender.yml
package:
  name: mips_core

export_include_dirs:
  - common

sources:
  - common/mipsPkg.sv
  - src/pcUnit.sv
  - decode/mipsDecoder.sv
  - regfile/regFile.sv
  - execute/execUnit.sv
  - src/mipsCore.sv
  - target: test
    files:
      - test/tbMipsCore.sv

//--- common/mipsPkg.sv
package mipsPkg;

  // ============================================================
  // instruction encodings
  // ============================================================

  // primary opcode, ir[31:26]
  typedef enum logic [5:0] {
    opRtype = 6'h00,
    opJ     = 6'h02,
    opJal   = 6'h03,
    opBeq   = 6'h04,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeE;

  // function field of r-type, ir[5:0]
  typedef enum logic [5:0] {
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } functE;

  // ============================================================
  // internal control
  // ============================================================

  // alu operation, none marks an illegal encoding
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluNone
  } aluOpE;

  // register write-back source
  typedef enum logic [1:0] {
    wbAlu,
    wbMem,
    wbLink
  } wbSelE;

endpackage

//--- common/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// ============================================================
// core sizing
// ============================================================

// data path and address width
`define MIPS_XLEN 32

// register index width, 32 registers
`define MIPS_REG_AW 5

// data memory word address, 128 words
`define MIPS_DMEM_AW 7

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

//--- compile.f
+incdir+common
common/mipsPkg.sv
src/pcUnit.sv
decode/mipsDecoder.sv
regfile/regFile.sv
execute/execUnit.sv
src/mipsCore.sv
test/tbMipsCore.sv

//--- decode/mipsDecoder.sv
`include "mips_cfg.svh"

module mipsDecoder (
  input  logic                    rst,
  input  logic [`MIPS_XLEN-1:0]   ir,
  output logic [`MIPS_REG_AW-1:0] rsIdx,
  output logic [`MIPS_REG_AW-1:0] rtIdx,
  output logic [`MIPS_REG_AW-1:0] wrIdx,
  output logic                    regWrite,
  output logic                    wen,
  output mipsPkg::aluOpE          aluOp,
  output logic                    immSel,
  output logic [`MIPS_XLEN-1:0]   imm,
  output mipsPkg::wbSelE          wbSel,
  output logic                    branch,
  output logic                    jump,
  output logic [25:0]             jumpIndex
);

  mipsPkg::opcodeE         opcode;
  mipsPkg::functE          funct;
  logic [`MIPS_REG_AW-1:0] rd;

  // ============================================================
  // field split
  // ============================================================
  assign opcode    = mipsPkg::opcodeE'(ir[31:26]);
  assign funct     = mipsPkg::functE'(ir[5:0]);
  assign rsIdx     = ir[25:21];
  assign rtIdx     = ir[20:16];
  assign rd        = ir[15:11];
  assign jumpIndex = ir[25:0];
  // sign extend the 16-bit immediate
  assign imm       = {{(`MIPS_XLEN-16){ir[15]}}, ir[15:0]};

  // ============================================================
  // main and alu control
  // ============================================================
  always_comb begin
    // defaults match an unknown opcode, nothing written
    regWrite = 1'b0;
    wen      = 1'b1;
    aluOp    = mipsPkg::aluNone;
    immSel   = 1'b0;
    // link source keeps aluNone off the alu write-back path
    wbSel    = mipsPkg::wbLink;
    branch   = 1'b0;
    jump     = 1'b0;
    wrIdx    = rd;
    case (opcode)
      mipsPkg::opRtype: begin
        wbSel = mipsPkg::wbAlu;
        case (funct)
          mipsPkg::fnAdd: aluOp = mipsPkg::aluAdd;
          mipsPkg::fnSub: aluOp = mipsPkg::aluSub;
          mipsPkg::fnAnd: aluOp = mipsPkg::aluAnd;
          mipsPkg::fnOr:  aluOp = mipsPkg::aluOr;
          mipsPkg::fnSlt: aluOp = mipsPkg::aluSlt;
          default:        wbSel = mipsPkg::wbLink;
        endcase
        regWrite = (aluOp != mipsPkg::aluNone);
      end
      mipsPkg::opLw: begin
        // address = rs + imm, result into rt
        aluOp    = mipsPkg::aluAdd;
        immSel   = 1'b1;
        wbSel    = mipsPkg::wbMem;
        wrIdx    = rtIdx;
        regWrite = 1'b1;
      end
      mipsPkg::opSw: begin
        aluOp  = mipsPkg::aluAdd;
        immSel = 1'b1;
        wen    = 1'b0;
      end
      mipsPkg::opBeq: begin
        // rs - rt, zero flag decides
        aluOp  = mipsPkg::aluSub;
        branch = 1'b1;
      end
      mipsPkg::opJ: jump = 1'b1;
      mipsPkg::opJal: begin
        // pc + 8 into r31
        jump     = 1'b1;
        wrIdx    = '1;
        regWrite = 1'b1;
      end
      default: ;
    endcase
    // no writes of either kind during reset
    if (!rst) begin
      regWrite = 1'b0;
      wen      = 1'b1;
    end
  end

  // only a store may pull the memory write enable
  always_comb begin
    assert final (wen || opcode == mipsPkg::opSw);
  end

endmodule

//--- execute/execUnit.sv
`include "mips_cfg.svh"

module execUnit (
  input  logic [`MIPS_XLEN-1:0] rsData,
  input  logic [`MIPS_XLEN-1:0] rtData,
  input  logic [`MIPS_XLEN-1:0] imm,
  input  mipsPkg::aluOpE        aluOp,
  input  logic                  immSel,
  input  mipsPkg::wbSelE        wbSel,
  input  logic [`MIPS_XLEN-1:0] memRdata,
  input  logic [`MIPS_XLEN-1:0] linkAddr,
  output logic [`MIPS_XLEN-1:0] aluResult,
  output logic                  zero,
  output logic [`MIPS_XLEN-1:0] wbData
);

  logic [`MIPS_XLEN-1:0] opB;
  logic                  lessThan;

  // ============================================================
  // alu
  // ============================================================
  // second operand, rt or immediate
  assign opB = immSel ? imm : rtData;

  // signed compare for slt
  assign lessThan = $signed(rsData) < $signed(opB);

  always_comb begin
    case (aluOp)
      mipsPkg::aluAdd: aluResult = rsData + opB;
      mipsPkg::aluSub: aluResult = rsData - opB;
      mipsPkg::aluAnd: aluResult = rsData & opB;
      mipsPkg::aluOr:  aluResult = rsData | opB;
      mipsPkg::aluSlt: aluResult = {{(`MIPS_XLEN-1){1'b0}}, lessThan};
      default:         aluResult = '0;
    endcase
  end

  // zero flag for every operation, only beq uses it
  assign zero = (aluResult == '0);

  // ============================================================
  // write-back select
  // ============================================================
  always_comb begin
    case (wbSel)
      mipsPkg::wbMem:  wbData = memRdata;
      mipsPkg::wbLink: wbData = linkAddr;
      default:         wbData = aluResult;
    endcase
  end

  // an illegal op must not feed the register file through the alu
  always_comb begin
    assert final (!(aluOp == mipsPkg::aluNone && wbSel == mipsPkg::wbAlu));
  end

endmodule

//--- regfile/regFile.sv
`include "mips_cfg.svh"

module regFile (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`MIPS_REG_AW-1:0] rsIdx,
  input  logic [`MIPS_REG_AW-1:0] rtIdx,
  input  logic [`MIPS_REG_AW-1:0] wrIdx,
  input  logic                    regWrite,
  input  logic [`MIPS_XLEN-1:0]   wrData,
  output logic [`MIPS_XLEN-1:0]   rsData,
  output logic [`MIPS_XLEN-1:0]   rtData
);

  localparam int NumRegs = 1 << `MIPS_REG_AW;

  logic [`MIPS_XLEN-1:0] regs [NumRegs];

  // ============================================================
  // write port
  // ============================================================
  // whole file cleared on reset, r0 never written
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && wrIdx != '0) begin
      regs[wrIdx] <= wrData;
    end
  end

  // ============================================================
  // read ports
  // ============================================================
  // combinational, r0 stays zero from reset on
  assign rsData = regs[rsIdx];
  assign rtData = regs[rtIdx];

  // r0 reads back zero even after a write to it
  assert property (@(posedge clk) disable iff (!rst)
    (rsIdx == '0) |-> (rsData == '0));

endmodule

//--- src/mipsCore.sv
`include "mips_cfg.svh"

module mipsCore (
  input  logic                      clk,
  input  logic                      rst,
  // instruction fetch
  input  logic [`MIPS_XLEN-1:0]     ir,
  output logic [`MIPS_XLEN-1:0]     irAddr,
  // data memory, word addressed
  input  logic [`MIPS_XLEN-1:0]     memRdata,
  output logic [`MIPS_DMEM_AW-1:0]  memAddr,
  output logic [`MIPS_XLEN-1:0]     memWdata,
  output logic                      wen,
  // value on the register write port
  output logic [`MIPS_XLEN-1:0]     rfWriteData
);

  // ============================================================
  // decoder outputs
  // ============================================================
  logic [`MIPS_REG_AW-1:0] rsIdx;
  logic [`MIPS_REG_AW-1:0] rtIdx;
  logic [`MIPS_REG_AW-1:0] wrIdx;
  logic                    regWrite;
  mipsPkg::aluOpE          aluOp;
  logic                    immSel;
  logic [`MIPS_XLEN-1:0]   imm;
  mipsPkg::wbSelE          wbSel;
  logic                    branch;
  logic                    jump;
  logic [25:0]             jumpIndex;

  // register file, execute and pc results
  logic [`MIPS_XLEN-1:0]   rsData;
  logic [`MIPS_XLEN-1:0]   rtData;
  logic [`MIPS_XLEN-1:0]   aluResult;
  logic [`MIPS_XLEN-1:0]   linkAddr;
  logic                    zero;

  mipsDecoder uDecoder (
    .rst(rst), .ir(ir), .rsIdx(rsIdx), .rtIdx(rtIdx), .wrIdx(wrIdx),
    .regWrite(regWrite), .wen(wen), .aluOp(aluOp), .immSel(immSel), .imm(imm),
    .wbSel(wbSel), .branch(branch), .jump(jump), .jumpIndex(jumpIndex)
  );

  regFile uRegFile (
    .clk(clk), .rst(rst), .rsIdx(rsIdx), .rtIdx(rtIdx), .wrIdx(wrIdx),
    .regWrite(regWrite), .wrData(rfWriteData), .rsData(rsData), .rtData(rtData)
  );

  execUnit uExec (
    .rsData(rsData), .rtData(rtData), .imm(imm), .aluOp(aluOp), .immSel(immSel),
    .wbSel(wbSel), .memRdata(memRdata), .linkAddr(linkAddr),
    .aluResult(aluResult), .zero(zero), .wbData(rfWriteData)
  );

  pcUnit uPc (
    .clk(clk), .rst(rst), .branch(branch), .jump(jump), .zero(zero),
    .imm(imm), .jumpIndex(jumpIndex), .pc(irAddr), .linkAddr(linkAddr)
  );

  // byte address to word address
  assign memAddr  = aluResult[`MIPS_DMEM_AW+1:2];
  // store data is always rt
  assign memWdata = rtData;

endmodule

//--- src/pcUnit.sv
`include "mips_cfg.svh"

module pcUnit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  branch,
  input  logic                  jump,
  input  logic                  zero,
  input  logic [`MIPS_XLEN-1:0] imm,
  input  logic [25:0]           jumpIndex,
  output logic [`MIPS_XLEN-1:0] pc,
  output logic [`MIPS_XLEN-1:0] linkAddr
);

  localparam int Xlen = `MIPS_XLEN;

  logic [Xlen-1:0] pcPlus4;
  logic [Xlen-1:0] branchTarget;
  logic [Xlen-1:0] jumpTarget;
  logic [Xlen-1:0] pcNext;

  // ============================================================
  // next pc
  // ============================================================
  assign pcPlus4      = pc + Xlen'(4);
  assign branchTarget = pcPlus4 + {imm[Xlen-3:0], 2'b00};
  // region bits from pc + 4, then index, word aligned
  assign jumpTarget   = {pcPlus4[Xlen-1:Xlen-4], jumpIndex, 2'b00};
  // jal link value
  assign linkAddr     = pc + Xlen'(8);

  always_comb begin
    if (jump) begin
      pcNext = jumpTarget;
    end else if (branch && zero) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= `MIPS_RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

  assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00);

endmodule

//--- test/program.hex
// one 32-bit instruction word per line, from word address 0 upward
// after the word: word address and assembly
8C010000 // 00 lw  r1, 0(r0)
8C020004 // 01 lw  r2, 4(r0)
00221820 // 02 add r3, r1, r2
00222022 // 03 sub r4, r1, r2
00222824 // 04 and r5, r1, r2
00223025 // 05 or  r6, r1, r2
0022382A // 06 slt r7, r1, r2
AC030010 // 07 sw  r3, 16(r0)
8C080010 // 08 lw  r8, 16(r0)
00220020 // 09 add r0, r1, r2
AC000014 // 0a sw  r0, 20(r0)
10210001 // 0b beq r1, r1, +1 taken
00214820 // 0c add r9, r1, r1 skipped
10220001 // 0d beq r1, r2, +1 not taken
0C000011 // 0e jal 0x11
03E05020 // 0f add r10, r31, r0 skipped
00215820 // 10 add r11, r1, r1 skipped
AC1F0018 // 11 sw  r31, 24(r0)
08000012 // 12 j   0x12 final loop

//--- test/tbMipsCore.sv
`include "mips_cfg.svh"

module tbMipsCore;
  timeunit 1ns;
  timeprecision 100ps;

  // program length plus margin
  localparam int CycleLimit = 80;
  localparam int NumTests = 6;
  localparam int ResetCycles = 5;
  // sw r0, 0(r0) on ir while in reset
  localparam logic [31:0] ResetStore = 32'hAC00_0000;

  logic                     clk;
  logic                     rst;
  logic [`MIPS_XLEN-1:0]    ir;
  logic [`MIPS_XLEN-1:0]    irAddr;
  logic [`MIPS_XLEN-1:0]    memRdata;
  logic [`MIPS_DMEM_AW-1:0] memAddr;
  logic [`MIPS_XLEN-1:0]    memWdata;
  logic                     wen;
  logic [`MIPS_XLEN-1:0]    rfWriteData;

  // memories outside the core
  logic [31:0] imem [64];
  logic [31:0] dmem [128];

  // ISA shadow model state
  logic [31:0] mPc;
  logic [31:0] mRegs [32];

  // model predictions, settled after the falling edge
  logic [31:0] expPc;
  logic [31:0] expNextPc;
  logic [31:0] expWdata;
  logic [31:0] expMemWdata;
  logic [6:0]  expMemAddr;
  logic [4:0]  expDest;
  logic        expWrite;
  logic        expWen;

  // test bookkeeping
  string testName [NumTests] = '{"reset", "alu", "load/store", "branch/jump", "jal", "r0"};
  logic [NumTests-1:0] testDone = '0;
  logic [NumTests-1:0] justDone = '0;
  logic [4:0]   aluSeen = '0;
  logic [2:0]   flowSeen = '0;
  logic [127:0] stored = '0;
  logic         r0Written = 1'b0;
  logic         finished = 1'b0;
  int           errors = 0;
  int           cycles = 0;

  mipsCore dut (
    .clk(clk), .rst(rst), .ir(ir), .irAddr(irAddr), .memRdata(memRdata),
    .memAddr(memAddr), .memWdata(memWdata), .wen(wen), .rfWriteData(rfWriteData)
  );

  // ============================================================
  // stimulus helpers
  // ============================================================
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per data bit
  task automatic fillDataMem();
    logic [31:0] state;
    logic [31:0] word;
    state = 32'h105d_6363;
    word = '0;
    for (int a = 0; a < 128; a++) begin
      for (int b = 0; b < 32; b++) begin
        state = lfsrStep(state);
        word = {word[30:0], state[0]};
      end
      dmem[a] = word;
    end
  endtask

  // ISA rules for the current instruction
  task automatic predict();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] pc4;
    a = mRegs[ir[25:21]];
    b = mRegs[ir[20:16]];
    imm = {{16{ir[15]}}, ir[15:0]};
    addr = a + imm;
    pc4 = mPc + 32'd4;
    expPc = mPc;
    expNextPc = pc4;
    expWrite = 1'b0;
    expWen = 1'b1;
    expDest = ir[15:11];
    expWdata = '0;
    expMemAddr = addr[8:2];
    expMemWdata = b;
    case (ir[31:26])
      // r-type
      6'h00: begin
        expWrite = 1'b1;
        case (ir[5:0])
          6'h20: expWdata = a + b;
          6'h22: expWdata = a - b;
          6'h24: expWdata = a & b;
          6'h25: expWdata = a | b;
          6'h2a: expWdata = {31'b0, $signed(a) < $signed(b)};
          default: expWrite = 1'b0;
        endcase
      end
      // lw
      6'h23: begin
        expWrite = 1'b1;
        expDest = ir[20:16];
        expWdata = dmem[addr[8:2]];
      end
      6'h2b: expWen = 1'b0;
      6'h04: if (a == b) expNextPc = pc4 + {imm[29:0], 2'b00};
      6'h02: expNextPc = {pc4[31:28], ir[25:0], 2'b00};
      // jal links pc + 8 into r31
      6'h03: begin
        expWrite = 1'b1;
        expDest = 5'd31;
        expWdata = mPc + 32'd8;
        expNextPc = {pc4[31:28], ir[25:0], 2'b00};
      end
      default: ;
    endcase
  endtask

  task automatic markDone(input int n);
    if (!testDone[n]) begin
      testDone[n] = 1'b1;
      justDone[n] = 1'b1;
    end
  endtask

  // which tests the executed instruction completes
  task automatic classifyInstr();
    markDone(0);
    if (expWrite && expDest == 5'd0) r0Written = 1'b1;
    case (ir[31:26])
      6'h00: begin
        case (ir[5:0])
          6'h20: aluSeen[0] = 1'b1;
          6'h22: aluSeen[1] = 1'b1;
          6'h24: aluSeen[2] = 1'b1;
          6'h25: aluSeen[3] = 1'b1;
          6'h2a: aluSeen[4] = 1'b1;
          default: ;
        endcase
        if (&aluSeen) markDone(1);
      end
      6'h2b: begin
        stored[expMemAddr] = 1'b1;
        if (ir[20:16] == 5'd0 && r0Written) markDone(5);
      end
      6'h23: if (stored[expMemAddr]) markDone(2);
      // taken or not taken
      6'h04: begin
        if (expNextPc != expPc + 32'd4) flowSeen[0] = 1'b1;
        else flowSeen[1] = 1'b1;
      end
      6'h02: begin
        flowSeen[2] = 1'b1;
        // a jump to itself ends the program
        if (expNextPc == expPc) finished = 1'b1;
      end
      6'h03: markDone(4);
      default: ;
    endcase
    if (&flowSeen) markDone(3);
  endtask

  task automatic reportDone();
    for (int i = 0; i < NumTests; i++) begin
      if (justDone[i]) begin
        $display("test %0d (%s) finished at %0t, errors so far %0d",
                 i, testName[i], $time, errors);
      end
    end
    justDone = '0;
  endtask

  // ============================================================
  // clock, memories and model
  // ============================================================
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  // synchronous store, wen active low
  always @(posedge clk) begin
    if (!wen) dmem[memAddr] <= memWdata;
  end

  // fetch, then data reply once memAddr settles
  always @(negedge clk) begin
    reportDone();
    // a store held in reset must leave wen high
    if (cycles < ResetCycles) begin
      ir = ResetStore;
    end else begin
      ir = imem[irAddr[7:2]];
    end
    predict();
    #1;
    memRdata = dmem[memAddr];
  end

  always @(posedge clk) begin
    if (rst) begin
      if (expWrite && expDest != 5'd0) mRegs[expDest] <= expWdata;
      mPc <= expNextPc;
      classifyInstr();
    end
  end

  // ============================================================
  // checks
  // ============================================================
  aRstPc: assert property (@(posedge clk) !rst |-> irAddr == `MIPS_RESET_PC)
    else begin
      errors++;
      $display("MISMATCH t=%0t irAddr got %h expected %h in reset",
               $time, $sampled(irAddr), `MIPS_RESET_PC);
    end
  aRstWen: assert property (@(posedge clk) !rst |-> wen)
    else begin
      errors++;
      $display("MISMATCH t=%0t wen got %b expected 1 in reset", $time, $sampled(wen));
    end
  aPc: assert property (@(posedge clk) disable iff (!rst) irAddr == expPc)
    else begin
      errors++;
      $display("MISMATCH t=%0t irAddr got %h expected %h",
               $time, $sampled(irAddr), $sampled(expPc));
    end
  aWen: assert property (@(posedge clk) disable iff (!rst) wen == expWen)
    else begin
      errors++;
      $display("MISMATCH t=%0t wen got %b expected %b", $time, $sampled(wen), $sampled(expWen));
    end
  aMemAddr: assert property (@(posedge clk) disable iff (!rst)
    !expWen |-> memAddr == expMemAddr)
    else begin
      errors++;
      $display("MISMATCH t=%0t memAddr got %h expected %h",
               $time, $sampled(memAddr), $sampled(expMemAddr));
    end
  aMemWdata: assert property (@(posedge clk) disable iff (!rst)
    !expWen |-> memWdata == expMemWdata)
    else begin
      errors++;
      $display("MISMATCH t=%0t memWdata got %h expected %h",
               $time, $sampled(memWdata), $sampled(expMemWdata));
    end
  aWb: assert property (@(posedge clk) disable iff (!rst) expWrite |-> rfWriteData == expWdata)
    else begin
      errors++;
      $display("MISMATCH t=%0t rfWriteData got %h expected %h",
               $time, $sampled(rfWriteData), $sampled(expWdata));
    end

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    rst = 1'b0;
    ir = '0;
    memRdata = '0;
    for (int i = 0; i < 64; i++) imem[i] = '0;
    $readmemh("test/program.hex", imem);
    fillDataMem();
    for (int i = 0; i < 32; i++) mRegs[i] = '0;
    mPc = `MIPS_RESET_PC;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    while (!finished && cycles < CycleLimit) @(negedge clk);
    // last checks and reports settle
    @(posedge clk);
    #10;
    if (!finished) begin
      errors++;
      $display("timeout: program did not reach its final loop within %0d cycles", CycleLimit);
    end
    for (int i = 0; i < NumTests; i++) begin
      if (!testDone[i]) begin
        errors++;
        $display("test %0d (%s) was never reached", i, testName[i]);
      end
    end
    $display("tests finished %0d of %0d, errors %0d", $countones(testDone), NumTests, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
